// ==== Makefile ====
# Verilator build and run for the UART boot channel

VERILATOR ?= verilator
TOP       ?= tb_boot_top
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim.f ====
+incdir+verilog
verilog/boot_pkg.sv
verilog/uart_byte_if.sv
verilog/uart.sv
verilog/word_fifo.sv
verilog/bootloader.sv
verilog/boot_regs.sv
verilog/boot_top.sv
test/tb_boot_top.sv

// ==== test/tb_boot_top.sv ====
`timescale 1ns/100ps
`include "boot_consts.svh"

module tb_boot_top;
  import boot_pkg::*;

  // Bit periods per byte, with room for gaps and idle checks
  localparam int BYTE_BITS = 12;
  localparam int WATCHDOG_CYCLES = 2 * BYTE_BITS * (52 * 16 + 36 * 200 + 16 * 8) + 2000;

  logic                    clk = 1'b0;
  logic                    rst_n;
  logic [`BOOT_AXI_AW-1:0] s_axi_awaddr, s_axi_araddr;
  logic                    s_axi_awvalid, s_axi_awready, s_axi_wvalid, s_axi_wready;
  logic                    s_axi_bvalid, s_axi_bready, s_axi_arvalid, s_axi_arready;
  logic                    s_axi_rvalid, s_axi_rready;
  logic [3:0]              s_axi_wstrb;
  boot_word_t              s_axi_wdata, s_axi_rdata;
  axi_resp_t               s_axi_bresp, s_axi_rresp;
  logic                    rx, tx, mem_we;
  boot_word_t              mem_addr, mem_wdata;

  baud_div_t  baud;       // Divisor the line model follows
  string      test_name;
  boot_word_t we_addr_q[$];
  boot_word_t we_data_q[$];

  boot_top i_boot_top (.*);

  always #50 clk = ~clk;

  // Memory write monitor
  always @(negedge clk) begin
    if (rst_n && mem_we) begin
      we_addr_q.push_back(mem_addr);
      we_data_q.push_back(mem_wdata);
    end
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic compare_word(input boot_word_t exp, input boot_word_t act);
    if (act !== exp)
      abort_run($sformatf("FAIL %s expected %h actual %h", test_name, exp, act));
  endtask

  task automatic compare_resp(input axi_resp_t exp, input axi_resp_t act);
    if (act !== exp)
      abort_run($sformatf("FAIL %s expected %s actual %s", test_name, exp.name(), act.name()));
  endtask

  task automatic compare_baud(input baud_div_t exp, input baud_div_t act);
    if (act !== exp)
      abort_run($sformatf("FAIL %s expected %0d actual %0d", test_name, exp, act));
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #10;
  endtask

  task automatic axi_write(input logic [`BOOT_AXI_AW-1:0] addr, input boot_word_t data,
                           output axi_resp_t resp);
    s_axi_awaddr  = addr;
    s_axi_wdata   = data;
    s_axi_awvalid = 1'b1;
    s_axi_wvalid  = 1'b1;
    s_axi_bready  = 1'b1;
    @(negedge clk);
    while (!s_axi_awready) @(negedge clk);
    if (!s_axi_wready)
      abort_run("AXI wready did not rise together with awready");
    @(posedge clk);
    #10;
    s_axi_awvalid = 1'b0;
    s_axi_wvalid  = 1'b0;
    @(negedge clk);
    while (!s_axi_bvalid) @(negedge clk);
    resp = s_axi_bresp;
    @(posedge clk);
    #10;
    s_axi_bready = 1'b0;
  endtask

  task automatic axi_read(input logic [`BOOT_AXI_AW-1:0] addr, output boot_word_t data,
                          output axi_resp_t resp);
    s_axi_araddr  = addr;
    s_axi_arvalid = 1'b1;
    s_axi_rready  = 1'b1;
    @(negedge clk);
    while (!s_axi_arready) @(negedge clk);
    @(posedge clk);
    #10;
    s_axi_arvalid = 1'b0;
    @(negedge clk);
    while (!s_axi_rvalid) @(negedge clk);
    data = s_axi_rdata;
    resp = s_axi_rresp;
    @(posedge clk);
    #10;
    s_axi_rready = 1'b0;
  endtask

  task automatic set_baud(input baud_div_t div);
    axi_resp_t resp;
    axi_write(`BOOT_REG_BAUD, {19'd0, div}, resp);
    compare_resp(RESP_OKAY, resp);
    baud = div;
  endtask

  task automatic set_load(input logic en);
    axi_resp_t resp;
    axi_write(`BOOT_REG_CTRL, {31'd0, en}, resp);
    compare_resp(RESP_OKAY, resp);
  endtask

  // Start, eight data bits LSB first, stop
  task automatic uart_send_byte(input byte_t b);
    int i;
    rx = 1'b0;
    wait_cycles(int'(baud));
    for (i = 0; i < 8; i++) begin
      rx = b[i];
      wait_cycles(int'(baud));
    end
    rx = 1'b1;
    wait_cycles(int'(baud) + 2);
  endtask

  task automatic uart_send_word(input boot_word_t w);
    int k;
    for (k = 3; k >= 0; k--)
      uart_send_byte(w[8*k +: 8]);  // MSB first
  endtask

  task automatic uart_recv_word(output boot_word_t w);
    boot_word_t acc;
    byte_t      b;
    int         k, i;
    acc = '0;
    for (k = 0; k < 4; k++) begin
      @(negedge clk);
      while (tx !== 1'b0) @(negedge clk);
      repeat (baud / 2) @(negedge clk);  // Middle of start bit
      if (tx !== 1'b0)
        abort_run("Start bit on tx did not last half a bit period");
      for (i = 0; i < 8; i++) begin
        repeat (baud) @(negedge clk);
        b[i] = tx;
      end
      repeat (baud) @(negedge clk);
      if (tx !== 1'b1)
        abort_run("Stop bit on tx was missing");
      acc = {b, acc[31:8]};  // LSB first
    end
    w = acc;
  endtask

  // No frame may follow the last expected word
  task automatic line_idle();
    int quiet;
    quiet = 0;
    while (quiet < 2 * int'(baud)) begin
      @(negedge clk);
      if (tx !== 1'b1)
        abort_run("An unexpected frame started on tx after the last expected word");
      quiet++;
    end
    @(posedge clk);
    #10;
  endtask

  task automatic wait_writes(input int n);
    while (we_addr_q.size() < n) @(negedge clk);
    @(posedge clk);
    #10;
  endtask

  // Words are expected from address 0 upward
  task automatic load_words(input int n);
    boot_word_t words[$];
    boot_word_t w;
    int         i;
    we_addr_q.delete();
    we_data_q.delete();
    for (i = 0; i < n; i++) begin
      w = $urandom();
      words.push_back(w);
      uart_send_word(w);
    end
    wait_writes(n);
    compare_word(boot_word_t'(n), boot_word_t'(we_addr_q.size()));
    for (i = 0; i < n; i++) begin
      compare_word(boot_word_t'(i), we_addr_q[i]);
      compare_word(words[i], we_data_q[i]);
    end
  endtask

  task automatic debug_roundtrip(input int n_words, input int n_ok);
    boot_word_t words[$];
    boot_word_t got;
    axi_resp_t  resp, exp_resp;
    int         i, j;
    for (i = 0; i < n_words; i++)
      words.push_back($urandom());
    fork
      begin
        for (i = 0; i < n_words; i++) begin
          axi_write(`BOOT_REG_TXWORD, words[i], resp);
          exp_resp = (i < n_ok) ? RESP_OKAY : RESP_SLVERR;
          compare_resp(exp_resp, resp);
        end
      end
      begin
        for (j = 0; j < n_ok; j++) begin
          uart_recv_word(got);
          compare_word(words[j], got);
        end
      end
    join
    line_idle();
  endtask

  task automatic test_reset_regs();
    boot_word_t data;
    axi_resp_t  resp;
    test_name = "reset_regs";
    axi_read(`BOOT_REG_CTRL, data, resp);
    compare_resp(RESP_OKAY, resp);
    compare_word(32'h0, data);
    axi_read(`BOOT_REG_BAUD, data, resp);
    compare_resp(RESP_OKAY, resp);
    compare_baud(`BOOT_BAUD_RESET, baud_div_t'(data));
    axi_read(`BOOT_REG_STATUS, data, resp);
    compare_word(32'h0000_0001, data);  // FIFO empty
    set_baud(13'h1a5);
    axi_read(`BOOT_REG_BAUD, data, resp);
    compare_baud(13'h1a5, baud_div_t'(data));
    set_baud(`BOOT_BAUD_RESET);
    axi_write(4'h2, 32'hdead_beef, resp);
    compare_resp(RESP_SLVERR, resp);
    axi_write(`BOOT_REG_STATUS, 32'h0, resp);  // Read-only
    compare_resp(RESP_SLVERR, resp);
    axi_read(4'h6, data, resp);
    compare_resp(RESP_SLVERR, resp);
  endtask

  task automatic test_loading();
    boot_word_t data;
    axi_resp_t  resp;
    test_name = "loading";
    set_load(1'b1);
    load_words(8);
    axi_read(`BOOT_REG_STATUS, data, resp);
    compare_word(32'h0008_0001, data);
  endtask

  task automatic test_load_disable();
    boot_word_t data;
    axi_resp_t  resp;
    test_name = "load_disable";
    set_load(1'b0);
    axi_read(`BOOT_REG_STATUS, data, resp);
    compare_word(32'h0000_0001, data);
    we_addr_q.delete();
    uart_send_word($urandom());
    wait_cycles(4 * int'(baud));
    compare_word(32'd0, boot_word_t'(we_addr_q.size()));  // Nothing written
    set_load(1'b1);
    load_words(1);
  endtask

  task automatic test_fifo_overflow();
    boot_word_t data;
    axi_resp_t  resp;
    test_name = "fifo_overflow";
    set_baud(13'd200);
    debug_roundtrip(11, 9);
    axi_read(`BOOT_REG_STATUS, data, resp);
    compare_word(32'h1, data & 32'h3);  // Drained, nothing extra queued
  endtask

  task automatic test_baud_change();
    test_name = "baud_change";
    set_baud(13'd8);
    set_load(1'b0);  // Restart at address 0
    set_load(1'b1);
    load_words(2);
    debug_roundtrip(2, 2);
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    abort_run("TIMEOUT: the tests did not finish in the expected time");
  end

  initial begin
    void'($urandom(32'hd551));
    rst_n         = 1'b0;
    s_axi_awaddr  = '0;
    s_axi_awvalid = 1'b0;
    s_axi_wdata   = '0;
    s_axi_wstrb   = 4'hf;
    s_axi_wvalid  = 1'b0;
    s_axi_bready  = 1'b0;
    s_axi_araddr  = '0;
    s_axi_arvalid = 1'b0;
    s_axi_rready  = 1'b0;
    rx            = 1'b1;  // Idle line
    baud          = `BOOT_BAUD_RESET;
    test_name     = "reset";
    wait_cycles(3);
    rst_n = 1'b1;
    wait_cycles(2);
    test_reset_regs();
    test_loading();
    test_load_disable();
    test_name = "debug_send";
    debug_roundtrip(3, 3);
    test_fifo_overflow();
    test_baud_change();
    $display("Result: PASSED");
    $finish;
  end

endmodule

// ==== verilog/boot_consts.svh ====
`ifndef BOOT_CONSTS_SVH
`define BOOT_CONSTS_SVH

// Register offsets
`define BOOT_REG_CTRL   4'h0
`define BOOT_REG_BAUD   4'h4
`define BOOT_REG_TXWORD 4'h8
`define BOOT_REG_STATUS 4'hC

`define BOOT_AXI_AW     4

`define BOOT_FIFO_DEPTH 8
`define BOOT_BAUD_RESET 13'd16  // Bit period out of reset

`endif

// ==== verilog/boot_pkg.sv ====
package boot_pkg;

  typedef logic [31:0] boot_word_t;  // Memory, debug and AXI data
  typedef logic [7:0]  byte_t;
  typedef logic [12:0] baud_div_t;   // Clock cycles per bit

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axi_resp_t;

endpackage

// ==== verilog/boot_regs.sv ====
`timescale 1ns/100ps
`include "boot_consts.svh"

module boot_regs (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [`BOOT_AXI_AW-1:0] awaddr,
  input  logic                    awvalid,
  output logic                    awready,
  input  boot_pkg::boot_word_t    wdata,
  input  logic [3:0]              wstrb,
  input  logic                    wvalid,
  output logic                    wready,
  output boot_pkg::axi_resp_t     bresp,
  output logic                    bvalid,
  input  logic                    bready,
  input  logic [`BOOT_AXI_AW-1:0] araddr,
  input  logic                    arvalid,
  output logic                    arready,
  output boot_pkg::boot_word_t    rdata,
  output boot_pkg::axi_resp_t     rresp,
  output logic                    rvalid,
  input  logic                    rready,
  output logic                    load_en,
  output boot_pkg::baud_div_t     baud_div,
  output logic                    push,
  output boot_pkg::boot_word_t    push_word,
  input  logic                    fifo_full,
  input  logic                    fifo_empty,
  input  boot_pkg::boot_word_t    load_addr
);
  import boot_pkg::*;

  logic       wr_acc;
  axi_resp_t  wr_resp, rd_resp;
  boot_word_t rd_word;

  // Address and data together, nothing pending
  assign wr_acc    = awvalid && wvalid && !bvalid;
  assign awready   = wr_acc;
  assign wready    = wr_acc;
  assign arready   = arvalid && !rvalid;
  assign push      = wr_acc && (awaddr == `BOOT_REG_TXWORD) && !fifo_full;
  assign push_word = wdata;

  always_comb begin
    case (awaddr)
      `BOOT_REG_CTRL, `BOOT_REG_BAUD: wr_resp = RESP_OKAY;
      `BOOT_REG_TXWORD: wr_resp = fifo_full ? RESP_SLVERR : RESP_OKAY;
      default: wr_resp = RESP_SLVERR;  // STATUS or unmapped
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      load_en  <= 1'b0;
      baud_div <= `BOOT_BAUD_RESET;
    end else if (wr_acc) begin
      if (awaddr == `BOOT_REG_CTRL && wstrb[0])
        load_en <= wdata[0];
      if (awaddr == `BOOT_REG_BAUD && wstrb[0])
        baud_div[7:0] <= wdata[7:0];
      if (awaddr == `BOOT_REG_BAUD && wstrb[1])
        baud_div[12:8] <= wdata[12:8];
    end
  end

  always_comb begin
    rd_word = '0;
    rd_resp = RESP_OKAY;
    case (araddr)
      `BOOT_REG_CTRL:   rd_word = {31'd0, load_en};
      `BOOT_REG_BAUD:   rd_word = {19'd0, baud_div};
      `BOOT_REG_TXWORD: rd_word = '0;  // Write-only
      `BOOT_REG_STATUS: rd_word = {load_addr[15:0], 14'd0, fifo_full, fifo_empty};
      default:          rd_resp = RESP_SLVERR;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bvalid <= 1'b0;
      rvalid <= 1'b0;
    end else begin
      if (wr_acc)
        bvalid <= 1'b1;
      else if (bready)
        bvalid <= 1'b0;
      if (arready)
        rvalid <= 1'b1;
      else if (rready)
        rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_acc)
      bresp <= wr_resp;
    if (arready) begin
      rdata <= rd_word;
      rresp <= rd_resp;
    end
  end

  b_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bvalid && !bready |=> bvalid && $stable(bresp));

endmodule

// ==== verilog/boot_top.sv ====
`timescale 1ns/100ps
`include "boot_consts.svh"

module boot_top (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [`BOOT_AXI_AW-1:0] s_axi_awaddr,
  input  logic                    s_axi_awvalid,
  output logic                    s_axi_awready,
  input  boot_pkg::boot_word_t    s_axi_wdata,
  input  logic [3:0]              s_axi_wstrb,
  input  logic                    s_axi_wvalid,
  output logic                    s_axi_wready,
  output boot_pkg::axi_resp_t     s_axi_bresp,
  output logic                    s_axi_bvalid,
  input  logic                    s_axi_bready,
  input  logic [`BOOT_AXI_AW-1:0] s_axi_araddr,
  input  logic                    s_axi_arvalid,
  output logic                    s_axi_arready,
  output boot_pkg::boot_word_t    s_axi_rdata,
  output boot_pkg::axi_resp_t     s_axi_rresp,
  output logic                    s_axi_rvalid,
  input  logic                    s_axi_rready,
  input  logic                    rx,
  output logic                    tx,
  output boot_pkg::boot_word_t    mem_addr,
  output boot_pkg::boot_word_t    mem_wdata,
  output logic                    mem_we
);
  import boot_pkg::*;

  logic       load_en, push, pop, fifo_full, fifo_empty;
  baud_div_t  baud_div;
  boot_word_t push_word, pop_word;

  uart_byte_if link ();

  uart i_uart (
    .clk(clk), .rst_n(rst_n), .rx(rx), .tx(tx), .baud_div(baud_div), .link(link)
  );

  word_fifo #(.DEPTH(`BOOT_FIFO_DEPTH)) i_fifo (
    .clk(clk), .rst_n(rst_n), .push(push), .push_word(push_word), .pop(pop),
    .pop_word(pop_word), .full(fifo_full), .empty(fifo_empty)
  );

  bootloader i_loader (
    .clk(clk), .rst_n(rst_n), .load_en(load_en), .link(link), .pop(pop),
    .pop_word(pop_word), .empty(fifo_empty), .mem_addr(mem_addr),
    .mem_wdata(mem_wdata), .mem_we(mem_we)
  );

  // Load address doubles as the STATUS readback
  boot_regs i_regs (
    .clk(clk), .rst_n(rst_n),
    .awaddr(s_axi_awaddr), .awvalid(s_axi_awvalid), .awready(s_axi_awready),
    .wdata(s_axi_wdata), .wstrb(s_axi_wstrb), .wvalid(s_axi_wvalid),
    .wready(s_axi_wready), .bresp(s_axi_bresp), .bvalid(s_axi_bvalid),
    .bready(s_axi_bready), .araddr(s_axi_araddr), .arvalid(s_axi_arvalid),
    .arready(s_axi_arready), .rdata(s_axi_rdata), .rresp(s_axi_rresp),
    .rvalid(s_axi_rvalid), .rready(s_axi_rready),
    .load_en(load_en), .baud_div(baud_div), .push(push), .push_word(push_word),
    .fifo_full(fifo_full), .fifo_empty(fifo_empty), .load_addr(mem_addr)
  );

endmodule

// ==== verilog/bootloader.sv ====
`timescale 1ns/100ps

module bootloader (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 load_en,
  uart_byte_if.loader          link,
  output logic                 pop,
  input  boot_pkg::boot_word_t pop_word,
  input  logic                 empty,
  output boot_pkg::boot_word_t mem_addr,
  output boot_pkg::boot_word_t mem_wdata,
  output logic                 mem_we
);
  import boot_pkg::*;

  typedef enum logic {IDLE, WRITE} load_state_t;
  typedef enum logic [1:0] {STEADY, SPLIT, SEND} send_state_t;

  load_state_t load_state;
  send_state_t send_state;
  logic [1:0]  byte_cnt, sent_cnt;
  logic        load_en_q, flush, take;
  boot_word_t  tx_word;

  // A byte left over from while loading was off is thrown away on enable
  assign flush  = load_en && !load_en_q && link.rx_rdy;
  assign take   = load_en && load_en_q && link.rx_rdy && (load_state == IDLE);
  assign mem_we = (load_state == WRITE);
  assign link.clr_rx_rdy = take || flush;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      load_state <= IDLE;
      byte_cnt   <= '0;
      load_en_q  <= 1'b0;
    end else begin
      load_en_q <= load_en;
      if (!load_en) begin
        load_state <= IDLE;
        byte_cnt   <= '0;
      end else if (load_state == WRITE) begin
        load_state <= IDLE;
      end else if (take) begin
        byte_cnt <= byte_cnt + 2'd1;
        if (byte_cnt == 2'd3)
          load_state <= WRITE;  // Fourth byte in
      end
    end
  end

  // MSB first
  always_ff @(posedge clk) begin
    if (take)
      mem_wdata <= {mem_wdata[23:0], link.rx_data};
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      mem_addr <= '0;
    else if (!load_en)
      mem_addr <= '0;
    else if (mem_we)
      mem_addr <= mem_addr + 32'd1;
  end

  assign pop          = (send_state == STEADY) && !empty;
  assign link.trmt    = (send_state == SPLIT);
  assign link.tx_data = tx_word[7:0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      send_state <= STEADY;
      sent_cnt   <= '0;
    end else begin
      case (send_state)
        STEADY: if (!empty) send_state <= SPLIT;
        SPLIT:  send_state <= SEND;
        SEND: begin
          if (link.tx_done) begin
            sent_cnt   <= sent_cnt + 2'd1;
            send_state <= (sent_cnt == 2'd3) ? STEADY : SPLIT;
          end
        end
        default: send_state <= STEADY;
      endcase
    end
  end

  // LSB first, one byte per tx_done
  always_ff @(posedge clk) begin
    if (pop)
      tx_word <= pop_word;
    else if (send_state == SEND && link.tx_done)
      tx_word <= {8'h00, tx_word[31:8]};
  end

  we_single: assert property (@(posedge clk) disable iff (!rst_n) mem_we |=> !mem_we);

endmodule

// ==== verilog/uart.sv ====
`timescale 1ns/100ps

module uart (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                rx,
  output logic                tx,
  input  boot_pkg::baud_div_t baud_div,
  uart_byte_if.uart           link
);
  import boot_pkg::*;

  logic       rx_meta, rx_sync;
  logic       rx_busy, rx_mid, rx_end, rx_frame;
  baud_div_t  rx_cnt;
  logic [3:0] rx_bit;
  byte_t      rx_shift;

  logic       tx_busy, tx_end;
  baud_div_t  tx_cnt;
  logic [3:0] tx_bit;
  logic [9:0] tx_shift;

  // Line idles high
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
    end
  end

  assign rx_mid   = rx_busy && (rx_cnt == (baud_div >> 1));
  assign rx_end   = rx_busy && (rx_cnt == baud_div - 13'd1);
  assign rx_frame = rx_end && (rx_bit == 4'd9);  // End of stop bit

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_busy <= 1'b0;
      rx_cnt  <= '0;
      rx_bit  <= '0;
    end else if (!rx_busy) begin
      rx_cnt  <= '0;
      rx_bit  <= '0;
      rx_busy <= !rx_sync;
    end else if (rx_mid && rx_bit == 4'd0 && rx_sync) begin
      rx_busy <= 1'b0;  // Glitch, not a start bit
    end else if (rx_end) begin
      rx_cnt <= '0;
      rx_bit <= rx_bit + 4'd1;
      if (rx_bit == 4'd9)
        rx_busy <= 1'b0;
    end else begin
      rx_cnt <= rx_cnt + 13'd1;
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge clk) begin
    if (rx_mid && rx_bit >= 4'd1 && rx_bit <= 4'd8)
      rx_shift <= {rx_sync, rx_shift[7:1]};
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      link.rx_rdy <= 1'b0;
    else if (rx_frame)
      link.rx_rdy <= 1'b1;
    else if (link.clr_rx_rdy)
      link.rx_rdy <= 1'b0;
  end

  // Overrun drops the new byte so the pending one stays stable
  always_ff @(posedge clk) begin
    if (rx_frame && (!link.rx_rdy || link.clr_rx_rdy))
      link.rx_data <= rx_shift;
  end

  assign tx_end = tx_busy && (tx_cnt == baud_div - 13'd1);
  assign tx     = tx_shift[0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx_busy      <= 1'b0;
      tx_cnt       <= '0;
      tx_bit       <= '0;
      tx_shift     <= '1;
      link.tx_done <= 1'b0;
    end else begin
      link.tx_done <= 1'b0;
      if (link.trmt) begin
        tx_busy  <= 1'b1;
        tx_cnt   <= '0;
        tx_bit   <= '0;
        tx_shift <= {1'b1, link.tx_data, 1'b0};  // Stop, data, start
      end else if (tx_end) begin
        tx_cnt   <= '0;
        tx_bit   <= tx_bit + 4'd1;
        tx_shift <= {1'b1, tx_shift[9:1]};
        if (tx_bit == 4'd9) begin
          tx_busy      <= 1'b0;
          link.tx_done <= 1'b1;
        end
      end else if (tx_busy) begin
        tx_cnt <= tx_cnt + 13'd1;
      end
    end
  end

  // Sender waits for tx_done before the next frame
  trmt_idle: assert property (@(posedge clk) disable iff (!rst_n)
    link.trmt |-> !tx_busy);

endmodule

// ==== verilog/uart_byte_if.sv ====
`timescale 1ns/100ps

interface uart_byte_if;
  import boot_pkg::*;

  logic  rx_rdy;      // Held until cleared
  byte_t rx_data;
  logic  clr_rx_rdy;
  logic  trmt;        // One-cycle frame start
  byte_t tx_data;
  logic  tx_done;

  modport uart (
    output rx_rdy, rx_data, tx_done,
    input  clr_rx_rdy, trmt, tx_data
  );

  modport loader (
    input  rx_rdy, rx_data, tx_done,
    output clr_rx_rdy, trmt, tx_data
  );

endinterface

// ==== verilog/word_fifo.sv ====
`timescale 1ns/100ps

module word_fifo #(
  parameter int DEPTH = 8
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 push,
  input  boot_pkg::boot_word_t push_word,
  input  logic                 pop,
  output boot_pkg::boot_word_t pop_word,
  output logic                 full,
  output logic                 empty
);
  import boot_pkg::*;

  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  boot_word_t    mem [DEPTH];
  logic [PW-1:0] wr_ptr, rd_ptr;
  logic [CW-1:0] count;
  logic          do_push, do_pop;

  assign full     = (count == CW'(DEPTH));
  assign empty    = (count == '0);
  assign do_push  = push && !full;
  assign do_pop   = pop && !empty;
  assign pop_word = mem[rd_ptr];  // Head entry

  always_ff @(posedge clk) begin
    if (do_push)
      mem[wr_ptr] <= push_word;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push)
        wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_push)
        count <= count - 1'b1;
    end
  end

  no_push_full: assert property (@(posedge clk) disable iff (!rst_n) push |-> !full);
  no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty);

endmodule
